// File: common/mem_geom_pkg.sv
package mem_geom_pkg;

   //////////////////////////////////////////////////////////////////////
   // Memory geometry.
   //////////////////////////////////////////////////////////////////////

   localparam int cant_columnas_mem_datos = 4;   // Byte columns.
   localparam int cant_bits_dato_mem      = 32;  // Word width.
   localparam int bits_byte               = 8;   // Column width.
   localparam int profundidad_mem         = 256; // Words per column.

   // Derived address widths.
   localparam int bits_word_addr = $clog2(profundidad_mem);
   localparam int bits_byte_off  = $clog2(cant_columnas_mem_datos);
   localparam int bits_apb_addr  = bits_word_addr + bits_byte_off;

   //////////////////////////////////////////////////////////////////////
   // Width types.
   //////////////////////////////////////////////////////////////////////

   typedef logic [cant_bits_dato_mem-1:0]      word_t;
   typedef logic [bits_byte-1:0]               byte_t;
   typedef logic [cant_columnas_mem_datos-1:0] lane_mask_t; // One bit per column.
   typedef logic [bits_word_addr-1:0]          word_addr_t;
   typedef logic [bits_byte_off-1:0]           byte_off_t;
   typedef logic [bits_apb_addr-1:0]           apb_addr_t;  // Byte address.

endpackage

// File: common/mem_access_pkg.sv
package mem_access_pkg;

   //////////////////////////////////////////////////////////////////////
   // Access size select.
   //////////////////////////////////////////////////////////////////////

   localparam int bits_select = 3;

   typedef logic [bits_select-1:0] select_t;

   // Size field lives below the zero-extend bit.
   localparam int sel_unsigned_bit = 2;

   localparam logic [sel_unsigned_bit-1:0] sel_byte = 2'd1;
   localparam logic [sel_unsigned_bit-1:0] sel_half = 2'd2;
   localparam logic [sel_unsigned_bit-1:0] sel_word = 2'd3;

   //////////////////////////////////////////////////////////////////////
   // APB controller states.
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      st_idle,      // Waiting for a setup cycle.
      st_access,    // PREADY high, transfer ends.
      st_read_wait  // Read wait state.
   } apb_state_e;

endpackage

// File: common/lane_if.sv
`timescale 1ns/1ps

interface lane_if
   import mem_geom_pkg::*;
   ();

   word_addr_t word_addr; // Word index into every column.
   lane_mask_t lane_we;   // Per column write enable.
   word_t      wdata;     // Write data already in lane position.

   // Each column drives its own byte.
   wire word_t rdata;

   modport aligner (
      output word_addr,
      output lane_we,
      output wdata
   );

   modport column (
      input  word_addr,
      input  lane_we,
      input  wdata,
      output rdata
   );

   modport extractor (
      input rdata
   );

endinterface

// File: hw/apb_mem_ctrl.sv
`timescale 1ns/1ps

module apb_mem_ctrl
   import mem_geom_pkg::*;
   import mem_access_pkg::*;
(
   input  logic  i_clock,
   input  logic  i_rst_n,
   input  logic  i_psel,
   input  logic  i_penable,
   input  logic  i_pwrite,
   input  logic  i_acceso_invalido,
   input  word_t i_dato_leido,
   output logic  o_enable_etapa,
   output word_t o_prdata,
   output logic  o_pready,
   output logic  o_pslverr
);

   apb_state_e estado;
   logic       setup;

   assign setup = i_psel && !i_penable; // First cycle of a transfer.

   //////////////////////////////////////////////////////////////////////
   // Transfer sequencing.
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      if (!i_rst_n) begin
         estado         <= st_idle;
         o_enable_etapa <= 1'b0;
         o_prdata       <= '0;
         o_pready       <= 1'b0;
         o_pslverr      <= 1'b0;
      end
      else begin
         case (estado)
            st_idle: begin
               o_enable_etapa <= 1'b0;
               o_pready       <= 1'b0;
               o_pslverr      <= 1'b0;
               if (setup) begin
                  if (i_acceso_invalido) begin
                     // Error completes in the first access cycle.
                     estado    <= st_access;
                     o_pready  <= 1'b1;
                     o_pslverr <= 1'b1;
                     o_prdata  <= '0;
                  end
                  else if (i_pwrite) begin
                     estado         <= st_access;
                     o_pready       <= 1'b1;
                     o_enable_etapa <= 1'b1; // Columns write at end of access.
                     o_prdata       <= '0;
                  end
                  else begin
                     estado <= st_read_wait; // Column address taken now.
                  end
               end
            end

            st_read_wait: begin
               if (!i_psel) begin
                  estado <= st_idle; // Master dropped the transfer.
               end
               else begin
                  estado   <= st_access;
                  o_prdata <= i_dato_leido; // Column data now valid.
                  o_pready <= 1'b1;
               end
            end

            st_access: begin
               estado         <= st_idle;
               o_enable_etapa <= 1'b0;
               o_pready       <= 1'b0;
               o_pslverr      <= 1'b0;
            end

            default: begin
               estado <= st_idle;
            end
         endcase
      end
   end

endmodule

// File: mem_datos/input_logic_mem_datos.sv
`timescale 1ns/1ps

module input_logic_mem_datos
   import mem_geom_pkg::*;
   import mem_access_pkg::*;
(
   input  select_t   i_select_bytes_mem_datos,
   input  logic      i_enable_etapa,
   input  apb_addr_t i_address,
   input  word_t     i_dato_mem,
   output logic      o_acceso_invalido,
   lane_if.aligner   bus
);

   logic [sel_unsigned_bit-1:0] tam;
   byte_off_t                   offset;
   lane_mask_t                  mascara;
   logic                        invalido;

   assign tam    = i_select_bytes_mem_datos[sel_unsigned_bit-1:0];
   assign offset = i_address[bits_byte_off-1:0];

   assign bus.word_addr = i_address[bits_apb_addr-1:bits_byte_off];

   //////////////////////////////////////////////////////////////////////
   // Lane mask and alignment check.
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      mascara  = '0;
      invalido = 1'b0;
      case (tam)
         sel_word: begin
            mascara  = '1;
            invalido = (offset != '0); // Word must sit at offset 0.
         end
         sel_half: begin
            mascara  = lane_mask_t'(3) << (2 * offset[1]);
            invalido = offset[0];
         end
         sel_byte: begin
            mascara = lane_mask_t'(1) << offset; // Single lane.
         end
         default: begin
            invalido = 1'b1; // Size code 0.
         end
      endcase
   end

   // Data moves up to its lanes.
   assign bus.wdata = i_dato_mem << (bits_byte * offset);

   // Nothing written outside a valid write stage.
   assign bus.lane_we = (i_enable_etapa && !invalido) ? mascara : '0;

   assign o_acceso_invalido = invalido;

endmodule

// File: mem_datos/columna_mem_datos.sv
`timescale 1ns/1ps

module columna_mem_datos
   import mem_geom_pkg::*;
#(
   parameter int columna = 0 // Lane index.
)
(
   input logic    i_clock,
   lane_if.column bus
);

   byte_t mem [profundidad_mem];
   byte_t dato_leido;

   //////////////////////////////////////////////////////////////////////
   // Byte column storage.
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      if (bus.lane_we[columna]) begin
         mem[bus.word_addr] <= bus.wdata[columna*bits_byte +: bits_byte];
      end
   end

   // Read every cycle, one cycle latency.
   always_ff @(posedge i_clock) begin
      dato_leido <= mem[bus.word_addr];
   end

   assign bus.rdata[columna*bits_byte +: bits_byte] = dato_leido;

endmodule

// File: mem_datos/output_logic_mem_datos.sv
`timescale 1ns/1ps

module output_logic_mem_datos
   import mem_geom_pkg::*;
   import mem_access_pkg::*;
(
   input  select_t   i_select_bytes_mem_datos,
   input  byte_off_t i_byte_off,
   output word_t     o_dato_leido,
   lane_if.extractor bus
);

   byte_t                   byte_sel;
   logic [2*bits_byte-1:0]  half_sel;
   logic                    sin_signo;
   logic                    ext_byte;
   logic                    ext_half;

   //////////////////////////////////////////////////////////////////////
   // Lane select.
   //////////////////////////////////////////////////////////////////////

   assign byte_sel = bus.rdata[i_byte_off*bits_byte +: bits_byte];
   assign half_sel = bus.rdata[i_byte_off[1]*2*bits_byte +: 2*bits_byte];

   assign sin_signo = i_select_bytes_mem_datos[sel_unsigned_bit];

   // Fill bit for the upper part.
   assign ext_byte = !sin_signo && byte_sel[bits_byte-1];
   assign ext_half = !sin_signo && half_sel[2*bits_byte-1];

   //////////////////////////////////////////////////////////////////////
   // Right justify and extend.
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      case (i_select_bytes_mem_datos[sel_unsigned_bit-1:0])
         sel_byte:
            o_dato_leido = {{(cant_bits_dato_mem-bits_byte){ext_byte}}, byte_sel};
         sel_half:
            o_dato_leido = {{(cant_bits_dato_mem-2*bits_byte){ext_half}}, half_sel};
         sel_word:
            o_dato_leido = bus.rdata; // Whole word as stored.
         default:
            o_dato_leido = '0;
      endcase
   end

endmodule

// File: hw/mem_datos_top.sv
`timescale 1ns/1ps

module mem_datos_top
   import mem_geom_pkg::*;
   import mem_access_pkg::*;
(
   input  logic      i_clock,
   input  logic      i_rst_n,
   input  logic      i_psel,
   input  logic      i_penable,
   input  logic      i_pwrite,
   input  apb_addr_t i_paddr,
   input  word_t     i_pwdata,
   input  select_t   i_select_bytes,
   output word_t     o_prdata,
   output logic      o_pready,
   output logic      o_pslverr
);

   logic  enable_etapa;
   logic  acceso_invalido;
   word_t dato_leido;

   lane_if lanes ();

   //////////////////////////////////////////////////////////////////////
   // APB sequencing.
   //////////////////////////////////////////////////////////////////////

   apb_mem_ctrl ctrl_i (
      .i_clock           (i_clock),
      .i_rst_n           (i_rst_n),
      .i_psel            (i_psel),
      .i_penable         (i_penable),
      .i_pwrite          (i_pwrite),
      .i_acceso_invalido (acceso_invalido),
      .i_dato_leido      (dato_leido),
      .o_enable_etapa    (enable_etapa),
      .o_prdata          (o_prdata),
      .o_pready          (o_pready),
      .o_pslverr         (o_pslverr)
   );

   //////////////////////////////////////////////////////////////////////
   // Data path.
   //////////////////////////////////////////////////////////////////////

   input_logic_mem_datos input_i (
      .i_select_bytes_mem_datos (i_select_bytes),
      .i_enable_etapa           (enable_etapa),
      .i_address                (i_paddr),
      .i_dato_mem               (i_pwdata),
      .o_acceso_invalido        (acceso_invalido),
      .bus                      (lanes.aligner)
   );

   for (genvar g = 0; g < cant_columnas_mem_datos; g++) begin : g_columna
      columna_mem_datos #(.columna(g)) columna_i (
         .i_clock (i_clock),
         .bus     (lanes.column)
      );
   end

   output_logic_mem_datos output_i (
      .i_select_bytes_mem_datos (i_select_bytes),
      .i_byte_off               (i_paddr[bits_byte_off-1:0]), // Offset within the word.
      .o_dato_leido             (dato_leido),
      .bus                      (lanes.extractor)
   );

endmodule

// File: bench/tb_mem_datos.sv
`timescale 1ns/1ps

module tb_mem_datos
   import mem_geom_pkg::*;
   import mem_access_pkg::*;
();

   localparam int periodo    = 40; // Clock period in ns.
   localparam int max_espera = 8;  // Access cycles allowed before PREADY.
   localparam int margen     = 20; // Spare cycles on top of the test length.

   typedef struct packed {
      logic      escribir;
      select_t   sel;
      apb_addr_t addr;
      word_t     wdata;
      word_t     esperado;
      logic      err;
   } vector_t;

   logic      clock = 1'b0;
   logic      rst_n;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   word_t     pwdata;
   select_t   select_bytes;
   word_t     prdata;
   logic      pready;
   logic      pslverr;

   vector_t vectores [$];
   bit      cargado        = 1'b0;
   int      errores_dato   = 0;
   int      errores_flag   = 0;
   int      errores_espera = 0;
   int      errores_otros  = 0;

   always #(periodo/2) clock = ~clock;

   mem_datos_top dut_i (
      .i_clock        (clock),
      .i_rst_n        (rst_n),
      .i_psel         (psel),
      .i_penable      (penable),
      .i_pwrite       (pwrite),
      .i_paddr        (paddr),
      .i_pwdata       (pwdata),
      .i_select_bytes (select_bytes),
      .o_prdata       (prdata),
      .o_pready       (pready),
      .o_pslverr      (pslverr)
   );

   //////////////////////////////////////////////////////////////////////
   // Compare tasks.
   //////////////////////////////////////////////////////////////////////

   task automatic check_word(input string nombre, input word_t esperado, input word_t obtenido);
      if (obtenido !== esperado) begin
         $display("ERR %0t %s expected %h got %h", $time, nombre, esperado, obtenido);
         errores_dato++;
      end
   endtask

   task automatic check_bit(input string nombre, input logic esperado, input logic obtenido);
      if (obtenido !== esperado) begin
         $display("ERR %0t %s expected %b got %b", $time, nombre, esperado, obtenido);
         errores_flag++;
      end
   endtask

   // Access cycles spent with PREADY low.
   task automatic check_latency(input string nombre, input int esperado, input int obtenido);
      if (obtenido != esperado) begin
         $display("ERR %0t %s expected %0d got %0d", $time, nombre, esperado, obtenido);
         errores_espera++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Golden file.
   //////////////////////////////////////////////////////////////////////

   task automatic load_vectors();
      int        fd;
      int        campos;
      int        num_linea;
      string     linea;
      logic      op;
      select_t   sel;
      apb_addr_t addr;
      word_t     wdata;
      word_t     esperado;
      logic      err;
      fd = $fopen("bench/mem_datos_golden.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the golden file bench/mem_datos_golden.txt");
         errores_otros++;
         return;
      end
      num_linea = 0;
      while ($fgets(linea, fd) != 0) begin
         num_linea++;
         if (linea.len() < 2 || linea.getc(0) == "#") begin
            continue; // Comment or empty line.
         end
         campos = $sscanf(linea, "%h %h %h %h %h %h", op, sel, addr, wdata, esperado, err);
         if (campos != 6) begin
            $display("Golden line %0d could not be read", num_linea);
            errores_otros++;
         end
         else begin
            vectores.push_back('{op, sel, addr, wdata, esperado, err});
         end
      end
      $fclose(fd);
      if (vectores.size() == 0) begin
         $display("The golden file holds no transfers");
         errores_otros++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // APB master.
   //////////////////////////////////////////////////////////////////////

   // Called at a falling edge inside an access cycle.
   task automatic wait_pready(output logic listo, output int espera);
      listo  = 1'b0;
      espera = 0;
      while (!listo && espera < max_espera) begin
         if (pready) begin
            listo = 1'b1;
         end
         else begin
            @(negedge clock);
            espera++;
         end
      end
   endtask

   task automatic run_transfer(
      input  logic      escribir,
      input  apb_addr_t addr,
      input  select_t   sel,
      input  word_t     dato,
      output logic      err,
      output word_t     leido,
      output int        esperas
   );
      logic listo;
      psel         = 1'b1; // Setup cycle.
      penable      = 1'b0;
      pwrite       = escribir;
      paddr        = addr;
      pwdata       = escribir ? dato : '0;
      select_bytes = sel;
      @(negedge clock);
      penable = 1'b1;
      wait_pready(listo, esperas);
      err   = pslverr;
      leido = prdata;
      if (!listo) begin
         $display("PREADY never rose for the transfer at address %h (time %0t)", addr, $time);
         errores_otros++;
      end
      @(negedge clock);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(
      input  apb_addr_t addr,
      input  select_t   sel,
      input  word_t     dato,
      output logic      err,
      output word_t     leido,
      output int        esperas
   );
      run_transfer(1'b1, addr, sel, dato, err, leido, esperas);
   endtask

   task automatic apb_read(
      input  apb_addr_t addr,
      input  select_t   sel,
      output logic      err,
      output word_t     leido,
      output int        esperas
   );
      run_transfer(1'b0, addr, sel, '0, err, leido, esperas);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence.
   //////////////////////////////////////////////////////////////////////

   initial begin
      vector_t v;
      word_t   leido;
      logic    err;
      int      esperas;
      rst_n        = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      select_bytes = '0;
      load_vectors();
      cargado = 1'b1;
      repeat (3) @(negedge clock);
      rst_n = 1'b1;
      check_bit("o_pready", 1'b0, pready);   // Idle values out of reset.
      check_bit("o_pslverr", 1'b0, pslverr);
      check_word("o_prdata", '0, prdata);
      for (int i = 0; i < vectores.size(); i++) begin
         v = vectores[i];
         @(negedge clock); // Idle gap between transfers.
         if (v.escribir) begin
            apb_write(v.addr, v.sel, v.wdata, err, leido, esperas);
         end
         else begin
            apb_read(v.addr, v.sel, err, leido, esperas);
         end
         check_bit("o_pslverr", v.err, err);
         // One wait state for a valid read, none otherwise.
         check_latency("o_pready wait cycles", (v.escribir || v.err) ? 0 : 1, esperas);
         if (!v.escribir || v.err) begin
            check_word("o_prdata", v.esperado, leido);
         end
      end
      @(negedge clock);
      $display("Error count: prdata %0d, pslverr %0d, pready %0d, other %0d",
               errores_dato, errores_flag, errores_espera, errores_otros);
      if (errores_dato + errores_flag + errores_espera + errores_otros == 0) begin
         $display("NO ERRORS");
      end
      else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Four cycles per transfer at most, plus reset.
   initial begin
      longint limite;
      wait (cargado);
      limite = longint'(vectores.size()) * 4 * periodo + longint'(3 + margen) * periodo;
      #(limite);
      $display("Timeout, the run did not finish within %0d ns", limite);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: bench/mem_datos_golden.txt
# op sel addr wdata rdata err (all hex; op 1 = write, 0 = read)
# sel bits 1..0 give the size (1 byte, 2 half, 3 word); bit 2 asks for zero extension
# Word write and read back.
1 3 000 12345678 00000000 0
0 3 000 00000000 12345678 0
1 3 004 DEADBEEF 00000000 0
0 3 004 00000000 DEADBEEF 0
# Byte lanes of one word.
1 3 010 11223344 00000000 0
1 1 011 FFFFFFBB 00000000 0
0 3 010 00000000 1122BB44 0
1 1 010 000000AA 00000000 0
1 5 012 123456CC 00000000 0
1 1 013 000000DD 00000000 0
0 3 010 00000000 DDCCBBAA 0
# Halfwords at offsets 0 and 2.
1 2 020 AAAA8001 00000000 0
1 6 022 55557FFE 00000000 0
0 2 020 00000000 FFFF8001 0
0 6 020 00000000 00008001 0
0 2 022 00000000 00007FFE 0
0 6 022 00000000 00007FFE 0
0 3 020 00000000 7FFE8001 0
1 3 024 00000000 00000000 0
1 2 026 0000C3A5 00000000 0
0 2 026 00000000 FFFFC3A5 0
0 6 026 00000000 0000C3A5 0
0 2 024 00000000 00000000 0
# Byte loads, signed and unsigned.
1 3 030 807FF001 00000000 0
0 1 030 00000000 00000001 0
0 5 030 00000000 00000001 0
0 1 031 00000000 FFFFFFF0 0
0 5 031 00000000 000000F0 0
0 1 032 00000000 0000007F 0
0 5 032 00000000 0000007F 0
0 1 033 00000000 FFFFFF80 0
0 5 033 00000000 00000080 0
# Invalid accesses, then the memory is read back.
1 2 011 0000FFFF 00000000 1
1 6 013 0000FFFF 00000000 1
1 3 012 FFFFFFFF 00000000 1
1 0 010 FFFFFFFF 00000000 1
1 4 010 FFFFFFFF 00000000 1
0 2 011 00000000 00000000 1
0 3 012 00000000 00000000 1
0 0 010 00000000 00000000 1
0 7 011 00000000 00000000 1
0 3 010 00000000 DDCCBBAA 0
0 3 000 00000000 12345678 0
0 7 004 00000000 DEADBEEF 0

// File: vlog.f
common/mem_geom_pkg.sv
common/mem_access_pkg.sv
common/lane_if.sv
hw/apb_mem_ctrl.sv
mem_datos/input_logic_mem_datos.sv
mem_datos/columna_mem_datos.sv
mem_datos/output_logic_mem_datos.sv
hw/mem_datos_top.sv
bench/tb_mem_datos.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the data-memory testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_mem_datos

salida="$(./obj_dir/Vtb_mem_datos)"
echo "$salida"

if grep -qx "NO ERRORS" <<< "$salida"; then
   exit 0
else
   exit 1
fi
